// ==== common/masked_pkg.sv ====
// ====================
// Shared widths, latencies and share types for the masked A2B converter
// Modules pull these in with a wildcard import in their header
// ====================

package masked_pkg;

    // ====================
    // Widths and latencies
    // ====================
    localparam int DATA_W  = 16;            // Secret and share width
    localparam int ADD_LAT = DATA_W + 1;    // Masked adder, input to output
    localparam int TOP_LAT = ADD_LAT + 1;   // Encoder stage plus adder
    localparam int RND_W   = 3 * DATA_W;    // Two masks plus one gadget bit per adder bit

    // PRNG state size and fallback seeds
    localparam int SEED_W = 32;
    localparam logic [SEED_W-1:0] PRNG_SEED0 = 32'h2545_f491;  // Reset value, also replaces seed 0
    localparam logic [SEED_W-1:0] PRNG_SEED1 = 32'h9e37_79b9;  // Reset value of second state

    // ====================
    // Share types
    // ====================

    // One Boolean-shared bit, secret is sh0 ^ sh1
    typedef struct packed {
        logic sh0;
        logic sh1;
    } share2_t;

    // Bit i of the word is one shared bit
    typedef share2_t [DATA_W-1:0] bool_word_t;

    // Arithmetic pair, secret is a0 + a1 mod 2^DATA_W
    typedef struct packed {
        logic [DATA_W-1:0] a0;
        logic [DATA_W-1:0] a1;
    } arith_pair_t;

endpackage : masked_pkg

// ==== flist.f ====
common/masked_pkg.sv
masked_adder/masked_full_adder.sv
masked_adder/masked_boolean_adder.sv
src/share_encoder.sv
src/mask_prng.sv
src/masked_a2b_top.sv
test/a2b_checker.sv
test/tb_masked_a2b.sv

// ==== masked_adder/masked_boolean_adder.sv ====
// ====================
// Pipelined masked ripple-carry adder over two Boolean sharings
// One new addition per cycle, result after ADD_LAT cycles
// ====================
`timescale 1ns/10ps

module masked_boolean_adder import masked_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              zeroize_i,
    input  bool_word_t        x_i,        // First shared operand
    input  bool_word_t        y_i,        // Second shared operand
    input  logic [DATA_W-1:0] rnd_i,      // One fresh bit per bit position
    output bool_word_t        s_o         // Shared sum, deskewed
);

    // Carry into each bit position, carry[0] is a constant zero sharing
    share2_t [DATA_W-1:0] carry;

    assign carry[0] = '0;

    // ====================
    // Per-bit slice
    // ====================
    // Bit g waits g+1 stages for its carry, then DATA_W-g stages for the others
    for (genvar g = 0; g < DATA_W; g++) begin : g_bit
        share2_t [g:0]          x_dly;    // Operand skew, triangular
        share2_t [g:0]          y_dly;
        share2_t [DATA_W-1-g:0] s_dly;    // Sum deskew, triangular the other way
        share2_t                sum_c;    // Sum of this bit before deskew

        // Operand skew chain
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                x_dly <= '0;
                y_dly <= '0;
            end else if (zeroize_i) begin
                x_dly <= '0;
                y_dly <= '0;
            end else begin
                x_dly[0] <= x_i[g];                    // Entry stage
                y_dly[0] <= y_i[g];
                for (int j = 1; j <= g; j++) begin
                    x_dly[j] <= x_dly[j-1];
                    y_dly[j] <= y_dly[j-1];
                end
            end
        end

        if (g < DATA_W - 1) begin : g_fa
            // Carry out feeds the next bit one cycle later, in step with its skew
            masked_full_adder u_fa (
                .clk       (clk),
                .rst_n     (rst_n),
                .zeroize_i (zeroize_i),
                .x_i       (x_dly[g]),
                .y_i       (y_dly[g]),
                .c_i       (carry[g]),
                .rnd_i     (rnd_i[g]),
                .s_o       (sum_c),
                .c_o       (carry[g+1])
            );
        end else begin : g_msb
            // No carry out needed, linear XOR with a share refresh
            assign sum_c = x_dly[g] ^ y_dly[g] ^ carry[g] ^ share2_t'{rnd_i[g], rnd_i[g]};
        end

        // Sum deskew chain, first stage registers the bit sum
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                s_dly <= '0;
            end else if (zeroize_i) begin
                s_dly <= '0;
            end else begin
                s_dly[0] <= sum_c;
                for (int j = 1; j <= DATA_W - 1 - g; j++) begin
                    s_dly[j] <= s_dly[j-1];
                end
            end
        end

        assign s_o[g] = s_dly[DATA_W-1-g];              // Aligned across all bits
    end

endmodule : masked_boolean_adder

// ==== masked_adder/masked_full_adder.sv ====
// ====================
// One-bit masked full adder, two shares per bit
// Sum is combinational, carry leaves through a DOM AND with one cycle latency
// ====================
`timescale 1ns/10ps

module masked_full_adder import masked_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    zeroize_i,
    input  share2_t x_i,          // Operand bit x
    input  share2_t y_i,          // Operand bit y
    input  share2_t c_i,          // Incoming carry
    input  logic    rnd_i,        // Fresh bit for the cross terms
    output share2_t s_o,          // Sum, same cycle
    output share2_t c_o           // Carry, one cycle later
);

    share2_t a;                   // x ^ y
    share2_t b;                   // x ^ c
    logic inner0_q, inner1_q;     // Same-domain terms, x folded in
    logic cross0_q, cross1_q;     // Refreshed cross-domain terms

    // Share-wise linear part
    assign s_o.sh0 = x_i.sh0 ^ y_i.sh0 ^ c_i.sh0;
    assign s_o.sh1 = x_i.sh1 ^ y_i.sh1 ^ c_i.sh1;

    assign a.sh0 = x_i.sh0 ^ y_i.sh0;
    assign a.sh1 = x_i.sh1 ^ y_i.sh1;
    assign b.sh0 = x_i.sh0 ^ c_i.sh0;
    assign b.sh1 = x_i.sh1 ^ c_i.sh1;

    // ====================
    // DOM AND, maj = (a & b) ^ x
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inner0_q <= 1'b0;
            inner1_q <= 1'b0;
            cross0_q <= 1'b0;
            cross1_q <= 1'b0;
        end else if (zeroize_i) begin
            inner0_q <= 1'b0;
            inner1_q <= 1'b0;
            cross0_q <= 1'b0;
            cross1_q <= 1'b0;
        end else begin
            inner0_q <= (a.sh0 & b.sh0) ^ x_i.sh0;   // Domain 0 only
            inner1_q <= (a.sh1 & b.sh1) ^ x_i.sh1;   // Domain 1 only
            cross0_q <= (a.sh0 & b.sh1) ^ rnd_i;     // Cross term, refreshed
            cross1_q <= (a.sh1 & b.sh0) ^ rnd_i;
        end
    end

    // Compress only after the register stage, so glitches cannot mix domains
    assign c_o.sh0 = inner0_q ^ cross0_q;
    assign c_o.sh1 = inner1_q ^ cross1_q;

    // Carry shares are cleared one edge after a zeroize request
    a_carry_zeroized: assert property (
        @(posedge clk) disable iff (!rst_n)
        zeroize_i |=> (c_o == '0)
    ) else $error("Carry not cleared after zeroize");

endmodule : masked_full_adder

// ==== src/mask_prng.sv ====
// ====================
// Seedable xorshift source of fresh masks and gadget randomness
// Two 32-bit states step every cycle, low RND_W bits of the pair go out
// ====================
`timescale 1ns/10ps

module mask_prng import masked_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              seed_load_i,   // Load seed at this edge
    input  logic [SEED_W-1:0] seed_i,
    output logic [RND_W-1:0]  rnd_o
);

    logic [SEED_W-1:0]   s0_q, s1_q;         // Generator states
    logic [SEED_W-1:0]   seed_nz;            // Seed with zero replaced
    logic [2*SEED_W-1:0] state_cat;

    // Xorshift32 step, invertible so a nonzero state stays nonzero
    function automatic logic [SEED_W-1:0] xs32_step(input logic [SEED_W-1:0] s);
        logic [SEED_W-1:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        t = t ^ (t << 5);
        return t;
    endfunction

    assign seed_nz = (seed_i == '0) ? PRNG_SEED0 : seed_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s0_q <= PRNG_SEED0;
            s1_q <= PRNG_SEED1;
        end else if (seed_load_i) begin
            s0_q <= seed_nz;
            // Second state gets the halves swapped, still nonzero
            s1_q <= {seed_nz[SEED_W/2-1:0], seed_nz[SEED_W-1:SEED_W/2]};
        end else begin
            s0_q <= xs32_step(s0_q);
            s1_q <= xs32_step(s1_q);
        end
    end

    assign state_cat = {s1_q, s0_q};
    assign rnd_o     = state_cat[RND_W-1:0];   // Top bits of s1 unused

    // A zero state would lock the generator at zero forever
    a_state_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (s0_q != '0) && (s1_q != '0)
    ) else $error("PRNG state reached zero");

endmodule : mask_prng

// ==== src/masked_a2b_top.sv ====
// ====================
// Arithmetic to Boolean masking converter, first order, DATA_W bits
// Encode both shares, then add them with the masked ripple-carry adder
// ====================
`timescale 1ns/10ps

module masked_a2b_top import masked_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              zeroize_i,     // Clears every pipeline register
    input  logic              seed_load_i,
    input  logic [SEED_W-1:0] seed_i,
    input  logic              valid_i,       // One item per cycle at most
    input  arith_pair_t       shares_i,      // a0 + a1 is the secret
    output logic              valid_o,
    output bool_word_t        bool_o         // XOR of shares is the secret
);

    logic [RND_W-1:0]   rnd;                 // Fresh randomness, this cycle
    bool_word_t         enc0_bool;           // Boolean sharing of a0
    bool_word_t         enc1_bool;           // Boolean sharing of a1
    logic [TOP_LAT-1:0] valid_q;             // Valid tag shift register

    // ====================
    // Randomness and encoders
    // ====================
    mask_prng u_prng (
        .clk         (clk),
        .rst_n       (rst_n),
        .seed_load_i (seed_load_i),
        .seed_i      (seed_i),
        .rnd_o       (rnd)
    );

    share_encoder u_enc0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize_i (zeroize_i),
        .share_i   (shares_i.a0),
        .mask_i    (rnd[DATA_W-1:0]),          // Mask for a0
        .bool_o    (enc0_bool)
    );

    share_encoder u_enc1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize_i (zeroize_i),
        .share_i   (shares_i.a1),
        .mask_i    (rnd[2*DATA_W-1:DATA_W]),   // Mask for a1
        .bool_o    (enc1_bool)
    );

    // Boolean sum of the two sharings gives the Boolean masking of a0 + a1
    masked_boolean_adder u_adder (
        .clk       (clk),
        .rst_n     (rst_n),
        .zeroize_i (zeroize_i),
        .x_i       (enc0_bool),
        .y_i       (enc1_bool),
        .rnd_i     (rnd[3*DATA_W-1:2*DATA_W]), // Gadget bits
        .s_o       (bool_o)
    );

    // ====================
    // Valid tracking
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (zeroize_i) begin
            valid_q <= '0;                       // In-flight items are dropped
        end else begin
            valid_q <= {valid_q[TOP_LAT-2:0], valid_i};
        end
    end

    assign valid_o = valid_q[TOP_LAT-1];

    // Each accepted item leaves exactly TOP_LAT edges later
    a_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n || zeroize_i)
        valid_i |-> ##TOP_LAT valid_o
    ) else $error("valid_o missing TOP_LAT cycles after valid_i");

    // And no output appears without a matching input
    a_no_spurious_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o |-> $past(valid_i, TOP_LAT)
    ) else $error("valid_o without a matching valid_i");

endmodule : masked_a2b_top

// ==== src/share_encoder.sv ====
// ====================
// Turns one arithmetic share into a Boolean sharing under a fresh mask
// One register stage, two instances run side by side
// ====================
`timescale 1ns/10ps

module share_encoder import masked_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              zeroize_i,
    input  logic [DATA_W-1:0] share_i,    // Arithmetic share, raw
    input  logic [DATA_W-1:0] mask_i,     // Fresh mask from the PRNG
    output bool_word_t        bool_o      // (share ^ mask, mask) per bit
);

    bool_word_t enc;                      // Encoded word before the register

    // Mask is applied before the flops, so the raw share is never stored
    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            enc[i].sh0 = share_i[i] ^ mask_i[i];
            enc[i].sh1 = mask_i[i];
        end
    end

    // ====================
    // Output register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bool_o <= '0;
        end else if (zeroize_i) begin
            bool_o <= '0;                 // Drop shares on request
        end else begin
            bool_o <= enc;
        end
    end

endmodule : share_encoder

// ==== test/a2b_checker.sv ====
// ====================
// Scoreboard for the masked A2B converter that watches the DUT ports only
// Predicts each secret on valid_i and compares it with the unmasked output
// ====================
`timescale 1ns/10ps

module a2b_checker import masked_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              zeroize_i,
    input  logic              valid_i,        // DUT input side
    input  arith_pair_t       shares_i,
    input  logic              ref_en_i,       // Use ref_i instead of own prediction
    input  logic [DATA_W-1:0] ref_i,
    input  logic              valid_out_i,    // DUT output side
    input  bool_word_t        bool_i,
    output int                err_cnt_o,
    output int                pending_o,      // Items still in flight
    output logic [DATA_W-1:0] last_sh1_o      // sh1 bits of the latest output
);

    logic [DATA_W-1:0] exp_q[$];              // Expected secrets, oldest first
    int                stamp_q[$];            // Entry cycle of each item
    int                cycle        = 0;
    int                out_cnt      = 0;
    int                unmasked_cnt = 0;      // Outputs where sh1 equals the secret
    logic              zero_seen    = 1'b0;

    initial begin
        err_cnt_o  = 0;
        pending_o  = 0;
        last_sh1_o = '0;
    end

    // ====================
    // Input side sampled on the rising edge
    // ====================
    always @(posedge clk) begin : watch_in
        logic [DATA_W-1:0] pred;
        pred = shares_i.a0 + shares_i.a1;     // Sum mod 2^DATA_W
        if (rst_n) begin
            if (zeroize_i) begin
                exp_q.delete();               // Everything in flight is dropped
                stamp_q.delete();
                zero_seen = 1'b1;
            end else if (valid_i === 1'b1) begin
                exp_q.push_back(ref_en_i ? ref_i : pred);
                stamp_q.push_back(cycle);
            end
            pending_o = exp_q.size();
            cycle++;
        end
    end

    // ====================
    // Output side sampled mid-cycle where it is stable
    // ====================
    always @(negedge clk) begin : watch_out
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] want;
        logic [DATA_W-1:0] sh1;
        int                lat;
        for (int i = 0; i < DATA_W; i++) begin
            got[i] = bool_i[i].sh0 ^ bool_i[i].sh1;   // Secret is the share XOR
            sh1[i] = bool_i[i].sh1;
        end
        if (rst_n !== 1'b1) begin
            // Flops are still settling at time zero
            if ($time > 0 && (valid_out_i !== 1'b0 || bool_i !== '0)) begin
                $display("Outputs not cleared while reset is held at %0t ns", $time);
                err_cnt_o++;
            end
        end else begin
            if (zero_seen) begin
                zero_seen = 1'b0;
                if (valid_out_i !== 1'b0 || bool_i !== '0) begin
                    $display("Outputs not cleared one cycle after zeroize at %0t ns", $time);
                    err_cnt_o++;
                end
            end
            if (valid_out_i === 1'b1) begin
                last_sh1_o = sh1;
                if (exp_q.size() == 0) begin
                    $display("Unexpected output at %0t ns, valid_o high with nothing in flight",
                             $time);
                    err_cnt_o++;
                end else begin
                    want = exp_q.pop_front();
                    lat  = cycle - stamp_q.pop_front();
                    out_cnt++;
                    if (got !== want) begin
                        $display("[FAIL] %0t ns: secret %h, expected %h", $time, got, want);
                        err_cnt_o++;
                    end
                    if (lat != TOP_LAT) begin
                        $display("[FAIL] %0t ns: latency %0d, expected %0d", $time, lat, TOP_LAT);
                        err_cnt_o++;
                    end
                    if (sh1 === got)
                        unmasked_cnt++;
                end
                pending_o = exp_q.size();
            end else if (valid_out_i !== 1'b0) begin
                $display("valid_o is unknown at %0t ns", $time);
                err_cnt_o++;
            end
        end
    end

    // Same input under a new seed must give a different sh1
    task automatic check_reseed(input logic [DATA_W-1:0] sh1_a,
                                input logic [DATA_W-1:0] sh1_b);
        if (sh1_a === sh1_b) begin
            $display("[FAIL] %0t ns: sh1 %h unchanged under a new PRNG seed", $time, sh1_a);
            err_cnt_o++;
        end
    endtask

    task automatic check_masking();
        if (out_cnt == 0 || unmasked_cnt == out_cnt) begin
            $display("[FAIL] %0t ns: sh1 equal to the secret in all %0d outputs",
                     $time, out_cnt);
            err_cnt_o++;
        end
    endtask

endmodule : a2b_checker

// ==== test/tb_masked_a2b.sv ====
// ====================
// Testbench for the masked A2B converter
// Runs table cases, random back-to-back pairs with a zeroize and a reseed check
// ====================
`timescale 1ns/10ps

module tb_masked_a2b import masked_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int TAB_LEN    = 12;
    localparam int N_RAND     = 200;
    localparam int ZERO_AT    = 150;        // Random index where zeroize hits
    localparam int WD_CYCLES  = TAB_LEN + N_RAND + 4 * TOP_LAT + 50;

    logic              clk;
    logic              rst_n;
    logic              zeroize;
    logic              seed_load;
    logic [SEED_W-1:0] seed;
    logic              valid_in;
    arith_pair_t       shares;
    logic              valid_out;
    bool_word_t        bool_out;
    logic              ref_en;              // Table entries carry their own sum
    logic [DATA_W-1:0] ref_val;
    int                err_cnt;
    int                pending;
    logic [DATA_W-1:0] last_sh1;

    logic [3*DATA_W-1:0] stim_tab [TAB_LEN];   // {a0, a1, expected}

    masked_a2b_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .zeroize_i   (zeroize),
        .seed_load_i (seed_load),
        .seed_i      (seed),
        .valid_i     (valid_in),
        .shares_i    (shares),
        .valid_o     (valid_out),
        .bool_o      (bool_out)
    );

    a2b_checker chk_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .zeroize_i   (zeroize),
        .valid_i     (valid_in),
        .shares_i    (shares),
        .ref_en_i    (ref_en),
        .ref_i       (ref_val),
        .valid_out_i (valid_out),
        .bool_i      (bool_out),
        .err_cnt_o   (err_cnt),
        .pending_o   (pending),
        .last_sh1_o  (last_sh1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Starts right after a falling edge and returns at the next one
    task automatic apply_item(input logic [DATA_W-1:0] a0, input logic [DATA_W-1:0] a1,
                              input logic use_ref, input logic [DATA_W-1:0] sum);
        valid_in  = 1'b1;
        shares.a0 = a0;
        shares.a1 = a1;
        ref_en    = use_ref;
        ref_val   = sum;
        @(negedge clk);
    endtask

    // Wait until every item in flight has come out
    task automatic drain();
        valid_in = 1'b0;
        ref_en   = 1'b0;
        do @(posedge clk); while (pending != 0);
        @(negedge clk);
    endtask

    task automatic reseed_run(input logic [SEED_W-1:0] s, output logic [DATA_W-1:0] sh1);
        seed_load = 1'b1;
        seed      = s;
        @(negedge clk);
        seed_load = 1'b0;
        repeat (2) @(negedge clk);
        apply_item(16'h3c5a, 16'h96e1, 1'b1, 16'hd33b);
        drain();
        sh1 = last_sh1;
    endtask

    // ====================
    // Stimulus
    // ====================
    initial begin : stimulus
        logic [31:0]       lcg;
        logic [DATA_W-1:0] ra0;
        logic [DATA_W-1:0] ra1;
        logic [DATA_W-1:0] sh1_a;
        logic [DATA_W-1:0] sh1_b;
        lcg       = 32'h63b2bf43;
        rst_n     = 1'b0;
        zeroize   = 1'b0;
        seed_load = 1'b0;
        seed      = '0;
        valid_in  = 1'b0;
        shares    = '0;
        ref_en    = 1'b0;
        ref_val   = '0;
        stim_tab[0]  = {16'hffff, 16'h0001, 16'h0000};   // Full carry ripple
        stim_tab[1]  = {16'h8000, 16'h8000, 16'h0000};   // Carry out of the MSB only
        stim_tab[2]  = {16'h0000, 16'h0000, 16'h0000};
        stim_tab[3]  = {16'h7fff, 16'h0001, 16'h8000};   // Ripple into the MSB
        stim_tab[4]  = {16'h1234, 16'h5678, 16'h68ac};
        stim_tab[5]  = {16'hffff, 16'hffff, 16'hfffe};
        stim_tab[6]  = {16'haaaa, 16'h5555, 16'hffff};   // No carries at all
        stim_tab[7]  = {16'h00ff, 16'h0001, 16'h0100};
        stim_tab[8]  = {16'h0001, 16'hfffe, 16'hffff};
        stim_tab[9]  = {16'h8001, 16'h7fff, 16'h0000};
        stim_tab[10] = {16'hc3a5, 16'h5a3c, 16'h1de1};
        stim_tab[11] = {16'h0f0f, 16'hf0f1, 16'h0000};

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < TAB_LEN; i++)
            apply_item(stim_tab[i][47:32], stim_tab[i][31:16], 1'b1, stim_tab[i][15:0]);

        // Random pairs back to back with a zeroize mid-stream
        for (int i = 0; i < N_RAND; i++) begin
            if (i == ZERO_AT) begin
                valid_in = 1'b0;
                zeroize  = 1'b1;
                @(negedge clk);
                zeroize  = 1'b0;
            end
            lcg = lcg_next(lcg);
            ra0 = lcg[31:16];
            lcg = lcg_next(lcg);
            ra1 = lcg[31:16];
            apply_item(ra0, ra1, 1'b0, '0);
        end
        drain();

        // Same secret under two seeds
        reseed_run(32'h1357_9bdf, sh1_a);
        reseed_run(32'h2468_ace0, sh1_b);
        chk_i.check_reseed(sh1_a, sh1_b);
        chk_i.check_masking();

        $display("Run complete, %0d error(s)", err_cnt);
        if (err_cnt == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles, the DUT did not drain", WD_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule : tb_masked_a2b
